// File: hdl/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data and address width
`define RV_XLEN 32

// Instruction word width
`define RV_ILEN 32

// Architectural register count, x0 included
`define RV_NREGS 32

// Bits needed to index a register
`define RV_RADDR_W 5

`endif

// File: hdl/rv_isa_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_isa_pkg;

  // Basic vector types of the ISA
  typedef logic [`RV_XLEN-1:0]    word_t;
  typedef logic [`RV_ILEN-1:0]    instr_t;
  typedef logic [`RV_RADDR_W-1:0] reg_addr_t;

  ////////////////////////////////////////
  // Major opcodes of the kept subset
  ////////////////////////////////////////
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  ////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

endpackage

`default_nettype wire

// File: hdl/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  import rv_isa_pkg::*;

  // Controller states, one instruction at a time
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_FETCH = 2'd1,
    ST_EXEC  = 2'd2,
    ST_MEM   = 2'd3
  } ctrl_state_e;

  // Decoded instruction
  typedef struct packed {
    alu_op_e   alu_op;
    logic      use_imm;    // Operand B from immediate
    logic      reg_we;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    logic      is_jal;
    logic      branch_ne;  // BNE instead of BEQ
  } ctrl_t;

  // One data memory access
  typedef struct packed {
    logic  we;
    word_t addr;
    word_t wdata;
  } lsu_cmd_t;

endpackage

`default_nettype wire

// File: hdl/rv_fetch_unit.sv
`default_nettype none

module rv_fetch_unit (
  input  logic               clk,
  input  logic               rst_ni,
  input  rv_isa_pkg::word_t  boot_addr_i,
  input  logic               fetch_start_i,
  input  logic               pc_set_i,
  input  rv_isa_pkg::word_t  pc_next_i,
  input  logic               instr_gnt_i,
  input  logic               instr_rvalid_i,
  input  rv_isa_pkg::instr_t instr_rdata_i,
  output logic               instr_req_o,
  output rv_isa_pkg::word_t  instr_addr_o,
  output logic               instr_valid_o,
  output rv_isa_pkg::instr_t instr_o,
  output rv_isa_pkg::word_t  pc_o
);

  import rv_isa_pkg::*;

  // Single fetch sequence
  typedef enum logic [1:0] {
    F_IDLE = 2'd0,
    F_REQ  = 2'd1,
    F_WAIT = 2'd2
  } fetch_state_e;

  fetch_state_e state_q;
  word_t        pc_q;
  instr_t       instr_q;
  logic         valid_q;

  // PC and handshake state
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= F_IDLE;
      pc_q    <= boot_addr_i;
      valid_q <= 1'b0;
    end else begin
      valid_q <= (state_q == F_WAIT) && instr_rvalid_i;
      if (pc_set_i) begin
        pc_q <= pc_next_i;
      end
      case (state_q)
        F_IDLE:  if (fetch_start_i) state_q <= F_REQ;
        // Address held until grant
        F_REQ:   if (instr_gnt_i) state_q <= F_WAIT;
        F_WAIT:  if (instr_rvalid_i) state_q <= F_IDLE;
        default: state_q <= F_IDLE;
      endcase
    end
  end

  // Instruction word kept until the next fetch returns
  always_ff @(posedge clk) begin
    if ((state_q == F_WAIT) && instr_rvalid_i) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o   = (state_q == F_REQ);
  assign instr_addr_o  = pc_q;
  assign instr_valid_o = valid_q;
  assign instr_o       = instr_q;
  assign pc_o          = pc_q;

endmodule

`default_nettype wire

// File: hdl/rv_decoder.sv
`default_nettype none

module rv_decoder (
  input  rv_isa_pkg::instr_t  instr_i,
  output rv_core_pkg::ctrl_t  ctrl_o
);

  import rv_isa_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_j, imm_u;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  ////////////////////////////////////////
  // Immediates, all sign extended
  ////////////////////////////////////////
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};

  ////////////////////////////////////////
  // Control word
  ////////////////////////////////////////
  always_comb begin
    // Defaults give a no-op
    ctrl_o        = '0;
    ctrl_o.alu_op = ALU_ADD;
    ctrl_o.rs1    = instr_i[19:15];
    ctrl_o.rs2    = instr_i[24:20];
    ctrl_o.rd     = instr_i[11:7];
    case (opcode)
      // rd = x0 + imm
      OPC_LUI: begin
        ctrl_o.rs1     = '0;
        ctrl_o.use_imm = 1'b1;
        ctrl_o.imm     = imm_u;
        ctrl_o.reg_we  = 1'b1;
      end
      // ADDI only
      OPC_OP_IMM: begin
        ctrl_o.use_imm = 1'b1;
        ctrl_o.imm     = imm_i;
        ctrl_o.reg_we  = (funct3 == 3'b000);
      end
      OPC_OP: begin
        ctrl_o.reg_we = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: ctrl_o.alu_op = ALU_ADD;
          10'b0100000_000: ctrl_o.alu_op = ALU_SUB;
          10'b0000000_111: ctrl_o.alu_op = ALU_AND;
          10'b0000000_110: ctrl_o.alu_op = ALU_OR;
          10'b0000000_100: ctrl_o.alu_op = ALU_XOR;
          default:         ctrl_o.reg_we = 1'b0;
        endcase
      end
      // Word accesses only
      OPC_LOAD: begin
        ctrl_o.use_imm = 1'b1;
        ctrl_o.imm     = imm_i;
        ctrl_o.is_load = (funct3 == 3'b010);
        ctrl_o.reg_we  = (funct3 == 3'b010);
      end
      OPC_STORE: begin
        ctrl_o.use_imm  = 1'b1;
        ctrl_o.imm      = imm_s;
        ctrl_o.is_store = (funct3 == 3'b010);
      end
      // BEQ and BNE, compare rs1 with rs2
      OPC_BRANCH: begin
        ctrl_o.imm       = imm_b;
        ctrl_o.is_branch = (funct3[2:1] == 2'b00);
        ctrl_o.branch_ne = funct3[0];
      end
      OPC_JAL: begin
        ctrl_o.imm    = imm_j;
        ctrl_o.is_jal = 1'b1;
        ctrl_o.reg_we = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rv_regfile.sv
`default_nettype none

`include "rv_defines.svh"

module rv_regfile (
  input  logic                  clk,
  input  rv_isa_pkg::reg_addr_t raddr_a_i,
  input  rv_isa_pkg::reg_addr_t raddr_b_i,
  input  logic                  we_i,
  input  rv_isa_pkg::reg_addr_t waddr_i,
  input  rv_isa_pkg::word_t     wdata_i,
  output rv_isa_pkg::word_t     rdata_a_o,
  output rv_isa_pkg::word_t     rdata_b_o
);

  import rv_isa_pkg::*;

  // x1 to x31, x0 is not stored
  word_t regs [1:`RV_NREGS-1];

  // Synchronous write, x0 dropped
  always_ff @(posedge clk) begin
    if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous reads
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

// File: hdl/rv_alu.sv
`default_nettype none

module rv_alu (
  input  rv_isa_pkg::alu_op_e op_i,
  input  rv_isa_pkg::word_t   operand_a_i,
  input  rv_isa_pkg::word_t   operand_b_i,
  output rv_isa_pkg::word_t   result_o,
  output logic                equal_o
);

  import rv_isa_pkg::*;

  word_t sum;
  word_t diff;

  // Adder also yields the load/store address
  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  always_comb begin
    case (op_i)
      ALU_ADD: result_o = sum;
      ALU_SUB: result_o = diff;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      default: result_o = sum;
    endcase
  end

  // Branch compare
  assign equal_o = (diff == '0);

endmodule

`default_nettype wire

// File: hdl/rv_lsu.sv
`default_nettype none

module rv_lsu (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  mem_start_i,
  input  rv_core_pkg::lsu_cmd_t cmd_i,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  rv_isa_pkg::word_t     data_rdata_i,
  output logic                  data_req_o,
  output logic                  data_we_o,
  output rv_isa_pkg::word_t     data_addr_o,
  output rv_isa_pkg::word_t     data_wdata_o,
  output logic                  mem_done_o,
  output rv_isa_pkg::word_t     load_data_o
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  typedef enum logic [1:0] {
    L_IDLE = 2'd0,
    L_REQ  = 2'd1,
    L_WAIT = 2'd2
  } lsu_state_e;

  lsu_state_e state_q;
  lsu_cmd_t   cmd_q;
  word_t      rdata_q;
  logic       done_q;

  // Handshake state
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= L_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= (state_q == L_WAIT) && data_rvalid_i;
      case (state_q)
        L_IDLE:  if (mem_start_i) state_q <= L_REQ;
        L_REQ:   if (data_gnt_i) state_q <= L_WAIT;
        L_WAIT:  if (data_rvalid_i) state_q <= L_IDLE;
        default: state_q <= L_IDLE;
      endcase
    end
  end

  // Command and read data
  always_ff @(posedge clk) begin
    if (mem_start_i && (state_q == L_IDLE)) begin
      cmd_q <= cmd_i;
    end
    if ((state_q == L_WAIT) && data_rvalid_i) begin
      rdata_q <= data_rdata_i;
    end
  end

  // Port driven from the stored command, stable until grant
  assign data_req_o   = (state_q == L_REQ);
  assign data_we_o    = cmd_q.we;
  assign data_addr_o  = cmd_q.addr;
  assign data_wdata_o = cmd_q.wdata;
  assign mem_done_o   = done_q;
  assign load_data_o  = rdata_q;

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
`default_nettype none

module rv_core (
  input  logic               clk,
  input  logic               rst_ni,
  // Static after reset
  input  rv_isa_pkg::word_t  boot_addr_i,
  input  logic               fetch_enable_i,
  output logic               core_busy_o,
  // Instruction memory port
  output logic               instr_req_o,
  output rv_isa_pkg::word_t  instr_addr_o,
  input  logic               instr_gnt_i,
  input  logic               instr_rvalid_i,
  input  rv_isa_pkg::instr_t instr_rdata_i,
  // Data memory port
  output logic               data_req_o,
  output logic               data_we_o,
  output rv_isa_pkg::word_t  data_addr_o,
  output rv_isa_pkg::word_t  data_wdata_o,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  rv_isa_pkg::word_t  data_rdata_i
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  ctrl_state_e ctrl_state_q, ctrl_state_d;

  // Stage handshakes
  logic     fetch_start, instr_valid, pc_set;
  logic     mem_start, mem_done, instr_done;
  logic     is_mem, alu_equal, taken;
  instr_t   instr;
  ctrl_t    ctrl;
  lsu_cmd_t lsu_cmd;

  // Datapath
  word_t pc, pc_plus4, pc_target, pc_next;
  word_t rdata_a, rdata_b, alu_b, alu_result;
  word_t load_data, wb_data;

  ////////////////////////////////////////
  // Controller
  ////////////////////////////////////////
  assign is_mem = ctrl.is_load | ctrl.is_store;

  always_comb begin
    ctrl_state_d = ctrl_state_q;
    fetch_start  = 1'b0;
    mem_start    = 1'b0;
    instr_done   = 1'b0;
    case (ctrl_state_q)
      ST_IDLE: begin
        if (fetch_enable_i) begin
          ctrl_state_d = ST_FETCH;
          fetch_start  = 1'b1;
        end
      end
      // Wait for the fetched word
      ST_FETCH: if (instr_valid) ctrl_state_d = ST_EXEC;
      ST_EXEC: begin
        if (is_mem) begin
          ctrl_state_d = ST_MEM;
          mem_start    = 1'b1;
        end else begin
          instr_done = 1'b1;
        end
      end
      ST_MEM:  if (mem_done) instr_done = 1'b1;
      default: ctrl_state_d = ST_IDLE;
    endcase
    // Retire, then next fetch or stop
    if (instr_done) begin
      ctrl_state_d = fetch_enable_i ? ST_FETCH : ST_IDLE;
      fetch_start  = fetch_enable_i;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_state_q <= ST_IDLE;
    end else begin
      ctrl_state_q <= ctrl_state_d;
    end
  end

  assign core_busy_o = (ctrl_state_q != ST_IDLE);

  ////////////////////////////////////////
  // Operands, writeback, next PC
  ////////////////////////////////////////
  assign alu_b     = ctrl.use_imm ? ctrl.imm : rdata_b;
  assign pc_plus4  = pc + word_t'(4);
  assign pc_target = pc + ctrl.imm;

  // BNE inverts the equality flag
  assign taken   = ctrl.is_jal | (ctrl.is_branch & (alu_equal ^ ctrl.branch_ne));
  assign pc_next = taken ? pc_target : pc_plus4;
  assign pc_set  = instr_done;

  // LUI comes through the adder with rs1 forced to x0
  assign wb_data = ctrl.is_load ? load_data :
                   ctrl.is_jal  ? pc_plus4  : alu_result;

  // Address from the adder, store data from rs2
  assign lsu_cmd = '{we: ctrl.is_store, addr: alu_result, wdata: rdata_b};

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////
  rv_fetch_unit fetch_unit_i (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_start_i  ( fetch_start    ),
    .pc_set_i       ( pc_set         ),
    .pc_next_i      ( pc_next        ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_valid_o  ( instr_valid    ),
    .instr_o        ( instr          ),
    .pc_o           ( pc             )
  );

  rv_decoder decoder_i (
    .instr_i ( instr ),
    .ctrl_o  ( ctrl  )
  );

  // Single write port, used only on retire
  rv_regfile regfile_i (
    .clk       ( clk                      ),
    .raddr_a_i ( ctrl.rs1                 ),
    .raddr_b_i ( ctrl.rs2                 ),
    .we_i      ( ctrl.reg_we & instr_done ),
    .waddr_i   ( ctrl.rd                  ),
    .wdata_i   ( wb_data                  ),
    .rdata_a_o ( rdata_a                  ),
    .rdata_b_o ( rdata_b                  )
  );

  rv_alu alu_i (
    .op_i        ( ctrl.alu_op ),
    .operand_a_i ( rdata_a     ),
    .operand_b_i ( alu_b       ),
    .result_o    ( alu_result  ),
    .equal_o     ( alu_equal   )
  );

  rv_lsu lsu_i (
    .clk           ( clk           ),
    .rst_ni        ( rst_ni        ),
    .mem_start_i   ( mem_start     ),
    .cmd_i         ( lsu_cmd       ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_rdata_i  ( data_rdata_i  ),
    .data_req_o    ( data_req_o    ),
    .data_we_o     ( data_we_o     ),
    .data_addr_o   ( data_addr_o   ),
    .data_wdata_o  ( data_wdata_o  ),
    .mem_done_o    ( mem_done      ),
    .load_data_o   ( load_data     )
  );

endmodule

`default_nettype wire

// File: verif/rv_core_asserts.sv
`default_nettype none

module rv_core_asserts (
  input logic                     clk,
  input logic                     rst_ni,
  input logic                     instr_req_i,
  input rv_isa_pkg::word_t        instr_addr_i,
  input logic                     instr_gnt_i,
  input logic                     data_req_i,
  input logic                     data_we_i,
  input rv_isa_pkg::word_t        data_addr_i,
  input rv_isa_pkg::word_t        data_wdata_i,
  input logic                     data_gnt_i,
  input logic                     core_busy_i,
  input rv_core_pkg::ctrl_state_e ctrl_state_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import rv_core_pkg::*;

  // Count of failed assertions
  int unsigned fail_count = 0;

  ////////////////////////////////////////
  // Request held until grant
  ////////////////////////////////////////
  a_instr_hold: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else begin
      $error("Instruction request dropped or changed before its grant");
      fail_count++;
    end

  a_data_hold: assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_i && !data_gnt_i |=>
      data_req_i && $stable({data_we_i, data_addr_i, data_wdata_i}))
    else begin
      $error("Data request dropped or changed before its grant");
      fail_count++;
    end

  // One port at a time
  a_one_port: assert property (@(posedge clk) disable iff (!rst_ni)
    !(instr_req_i && data_req_i))
    else begin
      $error("Requests on both memory ports at once");
      fail_count++;
    end

  // Idle controller leaves both ports quiet
  a_idle_not_busy: assert property (@(posedge clk) disable iff (!rst_ni)
    (ctrl_state_i == ST_IDLE) |-> !core_busy_i && !instr_req_i && !data_req_i)
    else begin
      $error("Core busy or a memory request while the controller is idle");
      fail_count++;
    end

endmodule

bind rv_core rv_core_asserts asserts_i (
  .clk          ( clk          ),
  .rst_ni       ( rst_ni       ),
  .instr_req_i  ( instr_req_o  ),
  .instr_addr_i ( instr_addr_o ),
  .instr_gnt_i  ( instr_gnt_i  ),
  .data_req_i   ( data_req_o   ),
  .data_we_i    ( data_we_o    ),
  .data_addr_i  ( data_addr_o  ),
  .data_wdata_i ( data_wdata_o ),
  .data_gnt_i   ( data_gnt_i   ),
  .core_busy_i  ( core_busy_o  ),
  .ctrl_state_i ( ctrl_state_q )
);

`default_nettype wire

// File: verif/rv_core_tb.sv
`default_nettype none

module rv_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import rv_isa_pkg::*;

  typedef struct packed {
    word_t addr;
    word_t data;
  } store_t;

  localparam word_t BOOT = 32'h0000_0200;

  logic   clk = 1'b0;
  logic   rst_ni, fetch_enable_i, core_busy_o;
  word_t  boot_addr_i, instr_addr_o, data_addr_o, data_wdata_o, data_rdata_i;
  logic   instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic   data_req_o, data_we_o, data_gnt_i, data_rvalid_i;
  instr_t instr_rdata_i;

  // Memories, word indexed
  instr_t imem [0:1023];
  word_t  dmem [0:255];

  integer seed;
  int     max_delay;
  instr_t prog [$];
  store_t exp_store [$];
  store_t arith_exp [$];
  word_t  exp_fetch [$];

  always #10 clk = ~clk;

  rv_core dut (.*);

  ////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////
  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, word_t got, word_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // Stimulus changes 1 ns after the edge
  task automatic skip_cycles(int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  function automatic int rand_delay();
    if (max_delay == 0) begin
      return 0;
    end
    return $unsigned($random(seed)) % (max_delay + 1);
  endfunction

  ////////////////////////////////////////
  // Encoders and reference
  ////////////////////////////////////////
  function automatic instr_t enc_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic instr_t enc_i(logic [6:0] opc, logic [2:0] f3, int rd, int rs1,
                                   logic [11:0] imm);
    return {imm, 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic instr_t enc_s(int rs1, int rs2, logic [11:0] imm);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic instr_t enc_b(logic [2:0] f3, int rs1, int rs2, logic [12:0] off);
    return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic instr_t enc_j(int rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'b1101111};
  endfunction

  function automatic instr_t enc_u(int rd, logic [19:0] upper);
    return {upper, 5'(rd), 7'b0110111};
  endfunction

  function automatic word_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic word_t ref_result(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      default: return a + b;
    endcase
  endfunction

  function automatic void expect_store(word_t addr, word_t data);
    store_t s;
    s.addr = addr;
    s.data = data;
    exp_store.push_back(s);
  endfunction

  ////////////////////////////////////////
  // Memory models
  ////////////////////////////////////////
  initial begin : imem_model
    word_t a;
    forever begin
      skip_cycles(1);
      if (rst_ni && instr_req_o) begin
        skip_cycles(rand_delay());
        a = instr_addr_o;
        if (exp_fetch.size() > 0) begin
          check_value("instr_addr_o", a, exp_fetch.pop_front());
        end
        instr_gnt_i = 1'b1;
        skip_cycles(1);
        instr_gnt_i = 1'b0;
        skip_cycles(rand_delay());
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = imem[a[11:2]];
        skip_cycles(1);
        instr_rvalid_i = 1'b0;
      end
    end
  end

  initial begin : dmem_model
    word_t a;
    forever begin
      skip_cycles(1);
      if (rst_ni && data_req_o) begin
        skip_cycles(rand_delay());
        a = data_addr_o;
        if (data_we_o) begin
          dmem[a[9:2]] = data_wdata_o;
        end
        data_gnt_i = 1'b1;
        skip_cycles(1);
        data_gnt_i = 1'b0;
        skip_cycles(rand_delay());
        data_rvalid_i = 1'b1;
        data_rdata_i  = dmem[a[9:2]];
        skip_cycles(1);
        data_rvalid_i = 1'b0;
      end
    end
  end

  // Granted stores against the expected list, mid cycle
  always @(negedge clk) begin : store_monitor
    store_t exp;
    if (rst_ni && data_req_o && data_gnt_i && data_we_o) begin
      if (exp_store.size() == 0) begin
        stop_with_failure($sformatf("Store to address %h when no store was expected",
                                    data_addr_o));
      end else begin
        exp = exp_store.pop_front();
        check_value("data_addr_o", data_addr_o, exp.addr);
        check_value("data_wdata_o", data_wdata_o, exp.data);
      end
    end
  end

  ////////////////////////////////////////
  // Programs
  ////////////////////////////////////////
  task automatic load_program();
    foreach (prog[k]) begin
      imem[BOOT[11:2] + k] = prog[k];
    end
    prog.delete();
  endtask

  // Two random operands, then each R-type op stored
  task automatic build_arith();
    word_t       va, vb;
    logic [19:0] hi_a, hi_b;
    logic [11:0] lo_a, lo_b;
    alu_op_e     ops [0:4] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR};
    logic [9:0]  fn [0:4] = '{10'b0000000_000, 10'b0100000_000, 10'b0000000_111,
                              10'b0000000_110, 10'b0000000_100};
    hi_a = $random(seed);
    lo_a = $random(seed);
    hi_b = $random(seed);
    lo_b = $random(seed);
    va = ref_result(ALU_ADD, {hi_a, 12'b0}, sext12(lo_a));
    vb = ref_result(ALU_ADD, {hi_b, 12'b0}, sext12(lo_b));
    prog.push_back(enc_u(1, hi_a));
    prog.push_back(enc_i(7'b0010011, 3'b000, 1, 1, lo_a));
    prog.push_back(enc_u(2, hi_b));
    prog.push_back(enc_i(7'b0010011, 3'b000, 2, 2, lo_b));
    for (int k = 0; k < 5; k++) begin
      prog.push_back(enc_r(fn[k][9:3], fn[k][2:0], 3, 1, 2));
      prog.push_back(enc_s(0, 3, 12'h200 + 12'(4 * k)));
      expect_store(32'h200 + 4 * k, ref_result(ops[k], va, vb));
    end
    // Result to x0 is dropped
    prog.push_back(enc_r(7'b0000000, 3'b000, 0, 1, 2));
    prog.push_back(enc_s(0, 0, 12'h214));
    expect_store(32'h214, '0);
    prog.push_back(enc_j(0, '0));
  endtask

  task automatic build_loads();
    logic [5:0]  idx;
    logic [11:0] imm;
    for (int k = 0; k < 4; k++) begin
      idx = $random(seed);
      imm = $random(seed);
      prog.push_back(enc_i(7'b0000011, 3'b010, 6, 0, {4'b0, idx, 2'b00}));
      prog.push_back(enc_i(7'b0010011, 3'b000, 7, 6, imm));
      prog.push_back(enc_s(0, 7, 12'h280 + 12'(4 * k)));
      expect_store(32'h280 + 4 * k, ref_result(ALU_ADD, dmem[idx], sext12(imm)));
    end
    prog.push_back(enc_j(0, '0));
  endtask

  // Skipped slots store to addresses never expected
  task automatic build_control();
    int trace [] = '{0, 1, 2, 3, 5, 6, 7, 8, 10, 11, 12, 14};
    prog.push_back(enc_i(7'b0010011, 3'b000, 1, 0, 12'd5));
    prog.push_back(enc_i(7'b0010011, 3'b000, 2, 0, 12'd5));
    prog.push_back(enc_i(7'b0010011, 3'b000, 3, 0, 12'd7));
    prog.push_back(enc_b(3'b000, 1, 2, 13'd8));
    prog.push_back(enc_s(0, 1, 12'h300));
    prog.push_back(enc_s(0, 1, 12'h304));
    prog.push_back(enc_b(3'b000, 1, 3, 13'd8));
    prog.push_back(enc_s(0, 3, 12'h308));
    prog.push_back(enc_b(3'b001, 1, 3, 13'd8));
    prog.push_back(enc_s(0, 1, 12'h30c));
    prog.push_back(enc_b(3'b001, 1, 2, 13'd8));
    prog.push_back(enc_s(0, 2, 12'h310));
    prog.push_back(enc_j(5, 21'd8));
    prog.push_back(enc_s(0, 1, 12'h314));
    prog.push_back(enc_s(0, 5, 12'h318));
    prog.push_back(enc_j(0, '0));
    expect_store(32'h304, 32'd5);
    expect_store(32'h308, 32'd7);
    expect_store(32'h310, 32'd5);
    // Link is the JAL address plus 4
    expect_store(32'h318, BOOT + 32'd48 + 32'd4);
    foreach (trace[k]) begin
      exp_fetch.push_back(BOOT + 4 * trace[k]);
    end
  endtask

  ////////////////////////////////////////
  // One run: reset, start, drain, stop
  ////////////////////////////////////////
  task automatic run_program(int delay_max);
    int n;
    max_delay = delay_max;
    skip_cycles(1);
    rst_ni = 1'b0;
    skip_cycles(2);
    rst_ni = 1'b1;
    check_value("instr_req_o", word_t'(instr_req_o), '0);
    check_value("data_req_o", word_t'(data_req_o), '0);
    check_value("core_busy_o", word_t'(core_busy_o), '0);
    fetch_enable_i = 1'b1;
    n = 0;
    while (!instr_req_o) begin
      skip_cycles(1);
      n++;
      if (n > 10) stop_with_failure("No instruction request after fetch_enable_i rose");
    end
    check_value("instr_addr_o", instr_addr_o, BOOT);
    n = 0;
    while (exp_store.size() > 0) begin
      skip_cycles(1);
      n++;
      if (n > 3000) stop_with_failure("Not all expected stores appeared");
    end
    if (exp_fetch.size() > 0) begin
      stop_with_failure("Not all expected instruction addresses were requested");
    end
    // Current instruction finishes, then idle
    fetch_enable_i = 1'b0;
    n = 0;
    while (core_busy_o) begin
      skip_cycles(1);
      n++;
      if (n > 200) stop_with_failure("core_busy_o stayed high after fetch_enable_i fell");
    end
    repeat (30) begin
      skip_cycles(1);
      if (instr_req_o) stop_with_failure("Instruction request after the core went idle");
    end
  endtask

  initial begin : main
    seed           = 11539;
    max_delay      = 0;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    // ADDI x0, x0, index as filler
    for (int i = 0; i < 1024; i++) begin
      imem[i] = enc_i(7'b0010011, 3'b000, 0, 0, 12'(i));
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = $random(seed);
    end

    // Same stores with zero and with long delays
    build_arith();
    load_program();
    arith_exp = exp_store;
    run_program(0);
    exp_store = arith_exp;
    run_program(7);

    build_loads();
    load_program();
    run_program(3);

    build_control();
    load_program();
    run_program(3);

    if (dut.asserts_i.fail_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_with_failure("Protocol assertions failed during the run");
    end
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/rv_fetch_unit.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
verif/rv_core_asserts.sv
verif/rv_core_tb.sv
